//--- l0_data_array.sv
// ---------------------------------------
// Line storage of the L0 cache
// Written by refill responses, read with
// the hit mask and the word offset
// ---------------------------------------

`timescale 1ns/1ps

`include "l0_icache_defines.svh"

module l0_data_array import l0_icache_pkg::*; (
  input  logic                                      clk_i,
  input  line_t                                     rsp_data_i,
  input  line_vec_t                                 validate_strb_i,
  input  line_vec_t                                 hit_i,
  input  logic [`L0_LINE_ALIGN-`L0_FETCH_ALIGN-1:0] word_offset_i,
  output word_t                                     data_o
);

  line_t data_q [`L0_LINE_COUNT];
  line_t hit_line;

  // Whole line is captured with the validate pulse
  always_ff @(posedge clk_i) begin
    for (int i = 0; i < `L0_LINE_COUNT; i++) begin
      if (validate_strb_i[i]) begin
        data_q[i] <= rsp_data_i;
      end
    end
  end

  // Hit mask is one-hot, so an AND-OR mux is enough
  always_comb begin
    hit_line = '0;
    for (int i = 0; i < `L0_LINE_COUNT; i++) begin
      hit_line |= {`L0_LINE_WIDTH{hit_i[i]}} & data_q[i];
    end
  end

  // Word 0 sits in the low bits of the line
  assign data_o = hit_line[word_offset_i*`L0_FETCH_DW +: `L0_FETCH_DW];

endmodule

//--- l0_icache.f
+incdir+.
l0_icache_pkg.sv
l0_tag_array.sv
l0_data_array.sv
l0_refill_ctrl.sv
l0_prefetcher.sv
l0_icache_top.sv
tb_l0_icache.sv

//--- l0_icache_defines.svh
// ---------------------------------------
// Width and count macros of the L0 cache
// Include in every file that sizes a port
// ---------------------------------------

`ifndef L0_ICACHE_DEFINES_SVH
`define L0_ICACHE_DEFINES_SVH

// Fetch port
`define L0_FETCH_AW 32
`define L0_FETCH_DW 32

// Line geometry
`define L0_LINE_WIDTH 128
`define L0_LINE_COUNT 4

// Byte offset bits of a line and of a word
`define L0_LINE_ALIGN 4
`define L0_FETCH_ALIGN 2

// Refill request id, port id on top of the prefetch flag
`define L0_ID_WIDTH 2

`endif

//--- l0_icache_input.txt
# Columns: name op addr(hex) prefetch_enable expected_word(hex) demand_reqs prefetch_reqs
# op is fetch, flush or stall; request counts are those raised while the vector runs
# Cold miss, then the rest of the line hits
cold_w0 fetch 00001000 0 5A5A1000 1 0
warm_w1 fetch 00001004 0 5A5A1004 0 0
warm_w2 fetch 00001008 0 5A5A1008 0 0
warm_w3 fetch 0000100C 0 5A5A100C 0 0
# Four more lines push the first one out round-robin
fill_l1 fetch 00001014 0 5A5A1014 1 0
fill_l2 fetch 00001028 0 5A5A1028 1 0
fill_l3 fetch 0000103C 0 5A5A103C 1 0
fill_l4 fetch 00001040 0 5A5A1040 1 0
evicted_l0 fetch 00001004 0 5A5A1004 1 0
# Flush drops every line
flush_all flush 00000000 0 00000000 0 0
after_flush fetch 00001020 0 5A5A1020 1 0
# Next-line prefetch
pf_hit fetch 00001024 1 5A5A1024 0 1
pf_line fetch 00001034 0 5A5A1034 0 0
pf_present fetch 00001028 1 5A5A1028 0 0
# Back-pressure on the request port
stall_miss stall 00002008 0 5A5A2008 1 0
pf_miss fetch 00003000 1 5A5A3000 1 1
pf_miss_next fetch 00003014 0 5A5A3014 0 0
# Prefetch victim skips the line being hit
pf_skip fetch 00001030 1 5A5A1030 0 1
skip_kept fetch 00001034 0 5A5A1034 0 0
skip_line fetch 0000104C 0 5A5A104C 0 0

//--- l0_icache_pkg.sv
// ---------------------------------------
// Shared vector types of the L0 cache
// Imported by every block of the design
// ---------------------------------------

`include "l0_icache_defines.svh"

package l0_icache_pkg;

  // Fetch side
  typedef logic [`L0_FETCH_AW-1:0] addr_t;
  typedef logic [`L0_FETCH_DW-1:0] word_t;

  // One full refill line
  typedef logic [`L0_LINE_WIDTH-1:0] line_t;

  // Address without its line offset
  typedef logic [`L0_FETCH_AW-`L0_LINE_ALIGN-1:0] tag_t;

  // One bit per line, used for hit and update strobes
  typedef logic [`L0_LINE_COUNT-1:0] line_vec_t;

  // Line index for the round-robin pointer
  typedef logic [$clog2(`L0_LINE_COUNT)-1:0] line_idx_t;

  // Refill request id
  typedef logic [`L0_ID_WIDTH-1:0] req_id_t;

endpackage

//--- l0_icache_top.sv
// ---------------------------------------
// L0 instruction cache for one fetch port
// Fully associative, refilled line by line
// from the next level with optional
// next-line prefetching
// ---------------------------------------

`timescale 1ns/1ps

`include "l0_icache_defines.svh"

module l0_icache_top import l0_icache_pkg::*; #(
  parameter logic [`L0_ID_WIDTH-2:0] L0_ID = '0
) (
  input  logic    clk_i,
  input  logic    rst_ni,
  input  logic    flush_valid_i,
  input  logic    enable_prefetching_i,

  input  addr_t   in_addr_i,
  input  logic    in_valid_i,
  output word_t   in_data_o,
  output logic    in_ready_o,

  output addr_t   out_req_addr_o,
  output req_id_t out_req_id_o,
  output logic    out_req_valid_o,
  input  logic    out_req_ready_i,

  input  line_t   out_rsp_data_i,
  input  logic    out_rsp_valid_i
);

  line_vec_t hit;
  logic      prefetch_hit;
  line_vec_t evict_strb;
  line_vec_t validate_strb;
  line_vec_t flush_strb;
  logic      evict_from_prefetch;
  logic      pending_refill;
  addr_t     lookup_addr;
  logic      prefetch_latch;
  addr_t     prefetch_addr;
  logic      prefetch_valid;
  logic      prefetch_ready;
  logic      out_req_is_prefetch;

  // Hit answers the fetch in the same cycle
  assign in_ready_o   = (|hit) & in_valid_i;
  assign out_req_id_o = {L0_ID, out_req_is_prefetch};

  l0_tag_array u_tag_array (
    .clk_i                 (clk_i),
    .rst_ni                (rst_ni),
    .fetch_addr_i          (in_addr_i),
    .prefetch_addr_i       (lookup_addr),
    .evict_strb_i          (evict_strb),
    .validate_strb_i       (validate_strb),
    .flush_strb_i          (flush_strb),
    .evict_from_prefetch_i (evict_from_prefetch),
    .hit_o                 (hit),
    .prefetch_hit_o        (prefetch_hit)
  );

  l0_data_array u_data_array (
    .clk_i           (clk_i),
    .rsp_data_i      (out_rsp_data_i),
    .validate_strb_i (validate_strb),
    .hit_i           (hit),
    .word_offset_i   (in_addr_i[`L0_LINE_ALIGN-1:`L0_FETCH_ALIGN]),
    .data_o          (in_data_o)
  );

  l0_refill_ctrl u_refill_ctrl (
    .clk_i                 (clk_i),
    .rst_ni                (rst_ni),
    .fetch_valid_i         (in_valid_i),
    .fetch_addr_i          (in_addr_i),
    .hit_i                 (hit),
    .flush_i               (flush_valid_i),
    .prefetch_latch_i      (prefetch_latch),
    .prefetch_addr_i       (prefetch_addr),
    .prefetch_valid_i      (prefetch_valid),
    .prefetch_ready_o      (prefetch_ready),
    .rsp_valid_i           (out_rsp_valid_i),
    .out_req_addr_o        (out_req_addr_o),
    .out_req_is_prefetch_o (out_req_is_prefetch),
    .out_req_valid_o       (out_req_valid_o),
    .out_req_ready_i       (out_req_ready_i),
    .evict_strb_o          (evict_strb),
    .validate_strb_o       (validate_strb),
    .flush_strb_o          (flush_strb),
    .evict_from_prefetch_o (evict_from_prefetch),
    .pending_refill_o      (pending_refill)
  );

  l0_prefetcher u_prefetcher (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .enable_i         (enable_prefetching_i),
    .fetch_addr_i     (in_addr_i),
    .fetch_hit_i      (in_ready_o),
    .pending_refill_i (pending_refill),
    .prefetch_hit_i   (prefetch_hit),
    .prefetch_ready_i (prefetch_ready),
    .lookup_addr_o    (lookup_addr),
    .latch_o          (prefetch_latch),
    .req_addr_o       (prefetch_addr),
    .req_valid_o      (prefetch_valid)
  );

  // The core holds a waiting fetch, the miss logic relies on it
  a_fetch_stable: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    in_valid_i && !in_ready_o |=> in_valid_i && $stable(in_addr_i)
  );

endmodule

//--- l0_prefetcher.sv
// ---------------------------------------
// Next-line prefetcher of the L0 cache
// Requests the line after a hitting fetch
// and holds it until the port takes it
// ---------------------------------------

`timescale 1ns/1ps

`include "l0_icache_defines.svh"

module l0_prefetcher import l0_icache_pkg::*; (
  input  logic  clk_i,
  input  logic  rst_ni,
  input  logic  enable_i,
  input  addr_t fetch_addr_i,
  input  logic  fetch_hit_i,
  input  logic  pending_refill_i,
  input  logic  prefetch_hit_i,
  input  logic  prefetch_ready_i,
  output addr_t lookup_addr_o,
  output logic  latch_o,
  output addr_t req_addr_o,
  output logic  req_valid_o
);

  tag_t  next_tag;
  logic  decide;
  logic  req_valid_q;
  addr_t req_addr_q;

  // Line following the fetch, offset bits cleared
  assign next_tag      = fetch_addr_i[`L0_FETCH_AW-1:`L0_LINE_ALIGN] + tag_t'(1);
  assign lookup_addr_o = {next_tag, `L0_LINE_ALIGN'(0)};

  // Only worth it when that line is absent and the port is free
  assign decide  = enable_i & fetch_hit_i & ~prefetch_hit_i & ~pending_refill_i;
  assign latch_o = decide & ~req_valid_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      req_valid_q <= 1'b0;
    end else if (latch_o) begin
      req_valid_q <= 1'b1;
    end else if (prefetch_ready_i) begin
      req_valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (latch_o) begin
      req_addr_q <= lookup_addr_o;
    end
  end

  assign req_addr_o  = req_addr_q;
  assign req_valid_o = req_valid_q;

endmodule

//--- l0_refill_ctrl.sv
// ---------------------------------------
// Refill control of the L0 cache
// Picks victims round-robin, tracks the
// one outstanding refill and arbitrates
// demand and prefetch requests
// ---------------------------------------

`timescale 1ns/1ps

`include "l0_icache_defines.svh"

module l0_refill_ctrl import l0_icache_pkg::*; (
  input  logic      clk_i,
  input  logic      rst_ni,
  input  logic      fetch_valid_i,
  input  addr_t     fetch_addr_i,
  input  line_vec_t hit_i,
  input  logic      flush_i,
  input  logic      prefetch_latch_i,
  input  addr_t     prefetch_addr_i,
  input  logic      prefetch_valid_i,
  output logic      prefetch_ready_o,
  input  logic      rsp_valid_i,
  output addr_t     out_req_addr_o,
  output logic      out_req_is_prefetch_o,
  output logic      out_req_valid_o,
  input  logic      out_req_ready_i,
  output line_vec_t evict_strb_o,
  output line_vec_t validate_strb_o,
  output line_vec_t flush_strb_o,
  output logic      evict_from_prefetch_o,
  output logic      pending_refill_o
);

  logic      miss;
  logic      last_miss_q;
  logic      last_prefetch_q;
  logic      evict_because_miss;
  logic      evict_because_prefetch;
  logic      evict_req;
  line_idx_t cnt_q, cnt_d;
  line_vec_t victim_q;
  logic      pending_q;
  logic      refill_ready;
  addr_t     refill_addr;

  assign miss = fetch_valid_i & ~(|hit_i) & ~pending_q;

  // Evict only on the first cycle of each cause
  assign evict_because_miss     = miss & ~last_miss_q;
  assign evict_because_prefetch = prefetch_latch_i & ~last_prefetch_q;
  assign evict_req              = evict_because_miss | evict_because_prefetch;
  assign evict_from_prefetch_o  = evict_because_prefetch;

  // ---------------------------------------
  // Victim selection
  // ---------------------------------------
  always_comb begin
    evict_strb_o = '0;
    cnt_d        = cnt_q;
    if (evict_req) begin
      evict_strb_o = line_vec_t'(1) << cnt_q;
      cnt_d        = cnt_q + line_idx_t'(1);
      // Never replace the line that the fetch is reading
      if (evict_strb_o == hit_i) begin
        evict_strb_o = line_vec_t'(1) << cnt_d;
        cnt_d        = cnt_q + line_idx_t'(2);
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (evict_req) begin
      victim_q <= evict_strb_o;
    end
  end

  // ---------------------------------------
  // Pending refill
  // ---------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cnt_q           <= '0;
      last_miss_q     <= 1'b0;
      last_prefetch_q <= 1'b0;
      pending_q       <= 1'b0;
    end else begin
      cnt_q           <= cnt_d;
      last_miss_q     <= miss;
      last_prefetch_q <= prefetch_latch_i;
      if (pending_q) begin
        if (|validate_strb_o) begin
          pending_q <= 1'b0;
        end
      end else if ((miss && refill_ready) || prefetch_latch_i) begin
        pending_q <= 1'b1;
      end
    end
  end

  assign validate_strb_o  = (rsp_valid_i && pending_q) ? victim_q : '0;
  assign flush_strb_o     = flush_i ? '1 : '0;
  assign pending_refill_o = pending_q;

  // ---------------------------------------
  // Request arbitration
  // ---------------------------------------
  assign refill_addr = {fetch_addr_i[`L0_FETCH_AW-1:`L0_LINE_ALIGN], `L0_LINE_ALIGN'(0)};

  // Demand misses go first
  always_comb begin
    out_req_addr_o        = prefetch_addr_i;
    out_req_is_prefetch_o = 1'b1;
    out_req_valid_o       = prefetch_valid_i;
    prefetch_ready_o      = out_req_ready_i;
    refill_ready          = 1'b0;
    if (miss) begin
      out_req_addr_o        = refill_addr;
      out_req_is_prefetch_o = 1'b0;
      out_req_valid_o       = 1'b1;
      prefetch_ready_o      = 1'b0;
      refill_ready          = out_req_ready_i;
    end
  end

  // ---------------------------------------
  // Assertions
  // ---------------------------------------
  a_evict_exclusive: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    !(evict_because_miss && evict_because_prefetch)
  );

  a_req_stable: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    out_req_valid_o && !out_req_ready_i |=> out_req_valid_o
      && $stable(out_req_addr_o) && $stable(out_req_is_prefetch_o)
  );

endmodule

//--- l0_tag_array.sv
// ---------------------------------------
// Tag and valid storage of the L0 cache
// Looks up the fetch and prefetch address
// in all lines and applies line updates
// ---------------------------------------

`timescale 1ns/1ps

`include "l0_icache_defines.svh"

module l0_tag_array import l0_icache_pkg::*; (
  input  logic      clk_i,
  input  logic      rst_ni,
  input  addr_t     fetch_addr_i,
  input  addr_t     prefetch_addr_i,
  input  line_vec_t evict_strb_i,
  input  line_vec_t validate_strb_i,
  input  line_vec_t flush_strb_i,
  input  logic      evict_from_prefetch_i,
  output line_vec_t hit_o,
  output logic      prefetch_hit_o
);

  tag_t      fetch_tag;
  tag_t      prefetch_tag;
  tag_t      tag_q [`L0_LINE_COUNT];
  line_vec_t valid_q;
  line_vec_t prefetch_hit;

  assign fetch_tag    = fetch_addr_i[`L0_FETCH_AW-1:`L0_LINE_ALIGN];
  assign prefetch_tag = prefetch_addr_i[`L0_FETCH_AW-1:`L0_LINE_ALIGN];

  // ---------------------------------------
  // Lookup
  // ---------------------------------------
  // Full compare against every valid line
  always_comb begin
    for (int i = 0; i < `L0_LINE_COUNT; i++) begin
      hit_o[i]        = valid_q[i] & (tag_q[i] == fetch_tag);
      prefetch_hit[i] = valid_q[i] & (tag_q[i] == prefetch_tag);
    end
  end

  assign prefetch_hit_o = |prefetch_hit;

  // ---------------------------------------
  // Updates
  // ---------------------------------------
  // New tag is written when the line is chosen as victim
  always_ff @(posedge clk_i) begin
    for (int i = 0; i < `L0_LINE_COUNT; i++) begin
      if (evict_strb_i[i]) begin
        tag_q[i] <= evict_from_prefetch_i ? prefetch_tag : fetch_tag;
      end
    end
  end

  // Victim stays invalid until its refill data arrives
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= '0;
    end else begin
      for (int i = 0; i < `L0_LINE_COUNT; i++) begin
        if (evict_strb_i[i]) begin
          valid_q[i] <= 1'b0;
        end else if (validate_strb_i[i]) begin
          valid_q[i] <= 1'b1;
        end
        // Flush wins over everything else
        if (flush_strb_i[i]) begin
          valid_q[i] <= 1'b0;
        end
      end
    end
  end

  // ---------------------------------------
  // Assertions
  // ---------------------------------------
  // Replacement must never leave two valid copies of one line
  a_hit_onehot: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    $onehot0(hit_o)
  );

endmodule

//--- tb_l0_icache.sv
// ---------------------------------------
// Testbench of the L0 instruction cache
// Reads fetch, flush and stall vectors,
// models the next level and checks words
// and refill request counts per vector
// ---------------------------------------

`timescale 1ns/1ps

`include "l0_icache_defines.svh"

module tb_l0_icache import l0_icache_pkg::*; ();

  localparam int CYCLES_PER_VECTOR = 60;

  logic    clk_i;
  logic    rst_ni;
  logic    flush_valid_i;
  logic    enable_prefetching_i;
  addr_t   in_addr_i;
  logic    in_valid_i;
  word_t   in_data_o;
  logic    in_ready_o;
  addr_t   out_req_addr_o;
  req_id_t out_req_id_o;
  logic    out_req_valid_o;
  logic    out_req_ready_i;
  line_t   out_rsp_data_i;
  logic    out_rsp_valid_i;

  // Vector storage
  string   vec_name[$];
  string   vec_op[$];
  addr_t   vec_addr[$];
  int      vec_pf[$];
  word_t   vec_word[$];
  int      vec_demand[$];
  int      vec_prefetch[$];

  int      error_count;
  int      pass_tests;
  int      fail_tests;
  int      demand_count;
  int      prefetch_count;
  addr_t   last_prefetch_addr;
  logic    rsp_busy;
  string   cur_test;
  int      limit_cycles = 0;
  int      cycle_count;

  l0_icache_top u_dut (
    .clk_i                (clk_i),
    .rst_ni               (rst_ni),
    .flush_valid_i        (flush_valid_i),
    .enable_prefetching_i (enable_prefetching_i),
    .in_addr_i            (in_addr_i),
    .in_valid_i           (in_valid_i),
    .in_data_o            (in_data_o),
    .in_ready_o           (in_ready_o),
    .out_req_addr_o       (out_req_addr_o),
    .out_req_id_o         (out_req_id_o),
    .out_req_valid_o      (out_req_valid_o),
    .out_req_ready_i      (out_req_ready_i),
    .out_rsp_data_i       (out_rsp_data_i),
    .out_rsp_valid_i      (out_rsp_valid_i)
  );

  initial begin : clock_gen
    clk_i = 1'b0;
    forever #20 clk_i = ~clk_i;
  end

  task automatic check_value(input string what, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (expected !== actual) begin
      $display("ERROR %0s %0s: expected %08h, actual %08h", cur_test, what, expected, actual);
      error_count++;
    end
  endtask

  // Word at byte address a holds a XOR 5A5A0000, word 0 in the low bits
  function automatic line_t rule_line(input addr_t addr);
    line_t line;
    addr_t base;
    base = {addr[`L0_FETCH_AW-1:`L0_LINE_ALIGN], `L0_LINE_ALIGN'(0)};
    for (int i = 0; i < `L0_LINE_WIDTH / `L0_FETCH_DW; i++) begin
      line[i*`L0_FETCH_DW +: `L0_FETCH_DW] = (base + addr_t'(4 * i)) ^ 32'h5A5A0000;
    end
    return line;
  endfunction

  // ---------------------------------------
  // Next level memory and request monitor
  // ---------------------------------------
  initial begin : memory_model
    int unsigned delay;
    addr_t       req_addr;
    out_rsp_valid_i = 1'b0;
    out_rsp_data_i  = '0;
    rsp_busy        = 1'b0;
    demand_count    = 0;
    prefetch_count  = 0;
    delay           = $urandom(61);
    forever begin
      @(negedge clk_i);
      if (rst_ni && out_req_valid_o && out_req_ready_i) begin
        rsp_busy = 1'b1;
        req_addr = out_req_addr_o;
        check_value("request port id", 32'(0), 32'(out_req_id_o[1]));
        if (out_req_id_o[0]) begin
          prefetch_count++;
          last_prefetch_addr = req_addr;
        end else begin
          demand_count++;
        end
        // Answer 1 to 4 cycles after the accepting edge
        delay = 1 + ($urandom % 4);
        repeat (delay) @(posedge clk_i);
        #2;
        out_rsp_data_i  = rule_line(req_addr);
        out_rsp_valid_i = 1'b1;
        @(posedge clk_i);
        #2;
        out_rsp_valid_i = 1'b0;
        rsp_busy        = 1'b0;
      end
    end
  end

  initial begin : watchdog
    cycle_count = 0;
    wait (limit_cycles != 0);
    while (cycle_count < limit_cycles) begin
      @(posedge clk_i);
      cycle_count++;
    end
    $display("Timeout: the tests did not finish within %0d clock cycles", limit_cycles);
    $display("Simulation FAILED");
    $finish;
  end

  // ---------------------------------------
  // Stimulus tasks
  // ---------------------------------------
  task automatic next_cycle();
    @(posedge clk_i);
    #2;
  endtask

  task automatic run_fetch(input addr_t addr, input logic pf, output word_t data);
    logic done;
    done                 = 1'b0;
    in_addr_i            = addr;
    in_valid_i           = 1'b1;
    enable_prefetching_i = pf;
    while (!done) begin
      @(negedge clk_i);
      if (in_ready_o) begin
        done = 1'b1;
        data = in_data_o;
      end
      next_cycle();
    end
    in_valid_i = 1'b0;
  endtask

  task automatic run_stall(input addr_t addr, input logic pf, output word_t data);
    out_req_ready_i      = 1'b0;
    in_addr_i            = addr;
    in_valid_i           = 1'b1;
    enable_prefetching_i = pf;
    // Next level refuses the request for three cycles
    repeat (3) begin
      @(negedge clk_i);
      check_value("request valid under stall", 32'(1), 32'(out_req_valid_o));
      check_value("request address under stall", {addr[31:4], 4'h0}, out_req_addr_o);
      check_value("fetch ready under stall", 32'(0), 32'(in_ready_o));
      next_cycle();
    end
    out_req_ready_i = 1'b1;
    run_fetch(addr, pf, data);
  endtask

  task automatic run_flush();
    flush_valid_i = 1'b1;
    next_cycle();
    flush_valid_i = 1'b0;
  endtask

  // Let any refill or prefetch of the vector finish
  task automatic wait_idle();
    logic busy;
    busy = 1'b1;
    while (busy) begin
      @(negedge clk_i);
      busy = out_req_valid_o | rsp_busy;
      next_cycle();
    end
  endtask

  // ---------------------------------------
  // Main sequence
  // ---------------------------------------
  initial begin : stimulus
    int                fd;
    int                code;
    string             tok;
    string             op;
    logic [8*128-1:0]  rest;
    addr_t             addr;
    int                pf;
    word_t             word;
    int                dem;
    int                pre;
    word_t             got;
    int                dem_start;
    int                pre_start;
    int                err_start;
    rst_ni               = 1'b0;
    flush_valid_i        = 1'b0;
    enable_prefetching_i = 1'b0;
    in_addr_i            = '0;
    in_valid_i           = 1'b0;
    out_req_ready_i      = 1'b1;
    error_count          = 0;
    pass_tests           = 0;
    fail_tests           = 0;
    cur_test             = "setup";
    got                  = '0;

    fd = $fopen("l0_icache_input.txt", "r");
    if (fd == 0) begin
      $display("Could not open the vector file l0_icache_input.txt");
      error_count++;
    end else begin
      while ($fscanf(fd, "%s", tok) == 1) begin
        if (tok[0] == "#") begin
          code = $fgets(rest, fd);
        end else begin
          code = $fscanf(fd, "%s %h %d %h %d %d", op, addr, pf, word, dem, pre);
          if (code != 6) begin
            $display("Vector %0s is malformed and was skipped", tok);
            error_count++;
          end else begin
            vec_name.push_back(tok);
            vec_op.push_back(op);
            vec_addr.push_back(addr);
            vec_pf.push_back(pf);
            vec_word.push_back(word);
            vec_demand.push_back(dem);
            vec_prefetch.push_back(pre);
          end
        end
      end
      $fclose(fd);
    end
    limit_cycles = CYCLES_PER_VECTOR * (vec_name.size() + 1);

    repeat (3) @(posedge clk_i);
    #2;
    rst_ni = 1'b1;

    cur_test  = "reset";
    err_start = error_count;
    @(negedge clk_i);
    check_value("request valid", 32'(0), 32'(out_req_valid_o));
    check_value("fetch ready", 32'(0), 32'(in_ready_o));
    next_cycle();
    if (error_count == err_start) begin
      pass_tests++;
      $display("test %0s: ok", cur_test);
    end else begin
      fail_tests++;
      $display("test %0s: failed", cur_test);
    end

    for (int i = 0; i < vec_name.size(); i++) begin
      cur_test  = vec_name[i];
      err_start = error_count;
      dem_start = demand_count;
      pre_start = prefetch_count;
      if (vec_op[i] == "flush") begin
        run_flush();
      end else if (vec_op[i] == "stall") begin
        run_stall(vec_addr[i], vec_pf[i][0], got);
      end else if (vec_op[i] == "fetch") begin
        run_fetch(vec_addr[i], vec_pf[i][0], got);
      end else begin
        $display("Vector %0s has an unknown operation %0s", cur_test, vec_op[i]);
        error_count++;
      end
      wait_idle();
      if (vec_op[i] != "flush") begin
        check_value("fetch word", vec_word[i], got);
      end
      check_value("demand requests", vec_demand[i], demand_count - dem_start);
      check_value("prefetch requests", vec_prefetch[i], prefetch_count - pre_start);
      // Prefetch always targets the line after the fetched one
      if (vec_prefetch[i] > 0) begin
        check_value("prefetch address", {vec_addr[i][31:4], 4'h0} + 32'h10, last_prefetch_addr);
      end
      if (error_count == err_start) begin
        pass_tests++;
        $display("test %0s: ok", cur_test);
      end else begin
        fail_tests++;
        $display("test %0s: failed", cur_test);
      end
    end

    $display("Tests passed: %0d, tests failed: %0d, errors: %0d",
             pass_tests, fail_tests, error_count);
    if (fail_tests == 0 && error_count == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule
